// ==== hw/ads_pkg.sv ====
// ======================================
// ADS1292 controller shared definitions
// SPI widths, host control codes, command
// bytes and the first opcode byte layout
// ======================================
package ads_pkg;

	// ======================================
	// widths
	// ======================================
	localparam int BYTE_W      = 8;                    // one SPI word
	localparam int FRAME_BYTES = 9;                    // status + ch1 + ch2
	localparam int FRAME_W     = BYTE_W * FRAME_BYTES; // 72-bit stream frame

	// ======================================
	// host control codes
	// ======================================
	localparam logic [2:0] CB_IDLE   = 3'd0;
	localparam logic [2:0] CB_SYSCMD = 3'd1; // uses command byte
	localparam logic [2:0] CB_WREG   = 3'd2; // uses reg addr + data in
	localparam logic [2:0] CB_RREG   = 3'd3; // uses reg addr
	localparam logic [2:0] CB_RDATAC = 3'd4;
	localparam logic [2:0] CB_SDATAC = 3'd5; // also stops a running stream

	// ======================================
	// command bytes
	// ======================================
	localparam logic [BYTE_W-1:0] CM_RESET  = 8'h06; // done on the reset pin
	localparam logic [BYTE_W-1:0] CM_START  = 8'h08; // done on the START pin
	localparam logic [BYTE_W-1:0] CM_STOP   = 8'h0A; // done on the START pin
	localparam logic [BYTE_W-1:0] CM_RDATAC = 8'h10;
	localparam logic [BYTE_W-1:0] CM_SDATAC = 8'h11;

	// register access opcodes
	localparam logic [2:0]        OP_RREG    = 3'b001;
	localparam logic [2:0]        OP_WREG    = 3'b010;
	localparam logic [BYTE_W-1:0] OP_NUM_ONE = 8'h00; // count - 1, single register

	// first opcode byte
	// either a plain command or opcode over register address
	typedef union packed {
		logic [BYTE_W-1:0] cmd;
		struct packed {
			logic [2:0] op;   // 001 read, 010 write
			logic [4:0] addr; // start register
		} fields;
	} ads_opcode_u;

endpackage

// ==== hw/ads_spi_master.sv ====
`timescale 1ns/1ps
// ======================================
// ADS SPI master, mode 1 (CPOL 0, CPHA 1)
// one byte out on MOSI and one byte in from
// MISO per request, idle-low clock
// ======================================
module ads_spi_master #(
	parameter int CLKS_PER_HALF_BIT = 7
) (
	input  logic                      i_CLK,
	input  logic                      i_RSTN,
	input  logic [ads_pkg::BYTE_W-1:0] i_tx_byte,
	input  logic                      i_tx_valid,
	output logic                      o_tx_ready,
	output logic [ads_pkg::BYTE_W-1:0] o_rx_byte,
	output logic                      o_rx_valid,
	output logic                      o_SPI_CLK,
	output logic                      o_SPI_MOSI,
	input  logic                      i_SPI_MISO
);

	localparam int HB_W = $clog2(CLKS_PER_HALF_BIT + 1);

	logic [HB_W-1:0]            r_half_cnt; // cycles inside a half bit
	logic [3:0]                 r_edge_cnt; // 16 clock edges per byte
	logic [ads_pkg::BYTE_W-1:0] r_tx_shift;
	logic [ads_pkg::BYTE_W-1:0] r_rx_shift;
	logic                       w_edge;

	// an SPI clock edge is due this cycle
	assign w_edge = !o_tx_ready && (r_half_cnt == HB_W'(CLKS_PER_HALF_BIT - 1));

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			o_tx_ready <= 1'b1;
			o_rx_valid <= 1'b0;
			o_SPI_CLK  <= 1'b0;
			o_SPI_MOSI <= 1'b0;
			r_half_cnt <= '0;
			r_edge_cnt <= '0;
		end else begin
			o_rx_valid <= 1'b0;
			if (i_tx_valid && o_tx_ready) begin
				o_tx_ready <= 1'b0; // byte accepted
				r_half_cnt <= '0;
				r_edge_cnt <= '0;
			end else if (w_edge) begin
				r_half_cnt <= '0;
				r_edge_cnt <= r_edge_cnt + 1'b1;
				o_SPI_CLK  <= ~o_SPI_CLK;
				if (!r_edge_cnt[0]) begin
					o_SPI_MOSI <= r_tx_shift[ads_pkg::BYTE_W-1]; // leading edge, drive
				end else if (r_edge_cnt == 4'd15) begin
					o_tx_ready <= 1'b1; // last trailing edge
					o_rx_valid <= 1'b1;
				end
			end else if (!o_tx_ready) begin
				r_half_cnt <= r_half_cnt + 1'b1;
			end
		end
	end

	// shift registers carry no control state
	always_ff @(posedge i_CLK) begin
		if (i_tx_valid && o_tx_ready) begin
			r_tx_shift <= i_tx_byte;
		end else if (w_edge && !r_edge_cnt[0]) begin
			r_tx_shift <= {r_tx_shift[ads_pkg::BYTE_W-2:0], 1'b0}; // msb first
		end
		if (w_edge && r_edge_cnt[0]) begin
			r_rx_shift <= {r_rx_shift[ads_pkg::BYTE_W-2:0], i_SPI_MISO}; // trailing edge, sample
			if (r_edge_cnt == 4'd15) begin
				o_rx_byte <= {r_rx_shift[ads_pkg::BYTE_W-2:0], i_SPI_MISO};
			end
		end
	end

	// requester must wait for ready before a new strobe
	a_no_strobe_busy: assert property (
		@(posedge i_CLK) disable iff (!i_RSTN)
		$rose(i_tx_valid) |-> o_tx_ready
	);

endmodule

// ==== hw/ads_frame_capture.sv ====
`timescale 1ns/1ps
// ======================================
// ADS frame capture
// DRDY sync and fall detect, 9-byte frame
// assembly, frame-done pulse
// ======================================
module ads_frame_capture (
	input  logic                        i_CLK,
	input  logic                        i_RSTN,
	input  logic                        i_ads_drdy_n,
	input  logic                        i_frame_start,
	input  logic [ads_pkg::BYTE_W-1:0]  i_rx_byte,
	input  logic                        i_rx_valid,
	output logic                        o_drdy_fall,
	output logic                        o_frame_done,
	output logic [ads_pkg::FRAME_W-1:0] o_frame_data
);

	localparam int CNT_W = $clog2(ads_pkg::FRAME_BYTES);

	logic [2:0]       r_drdy_q;   // two sync flops + previous sample
	logic [CNT_W-1:0] r_byte_cnt;
	logic             r_armed;    // inside a frame

	assign o_drdy_fall = r_drdy_q[2] & ~r_drdy_q[1];

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_drdy_q     <= '1; // pin idles high
			r_byte_cnt   <= '0;
			r_armed      <= 1'b0;
			o_frame_done <= 1'b0;
		end else begin
			r_drdy_q     <= {r_drdy_q[1:0], i_ads_drdy_n};
			o_frame_done <= 1'b0;
			if (i_frame_start) begin
				r_armed    <= 1'b1;
				r_byte_cnt <= '0;
			end else if (r_armed && i_rx_valid) begin
				r_byte_cnt <= r_byte_cnt + 1'b1;
				if (r_byte_cnt == CNT_W'(ads_pkg::FRAME_BYTES - 1)) begin
					r_armed      <= 1'b0; // ninth byte in
					o_frame_done <= 1'b1;
				end
			end
		end
	end

	// frame payload, msb first, held until the next frame's first byte
	always_ff @(posedge i_CLK) begin
		if (r_armed && i_rx_valid) begin
			o_frame_data <= {o_frame_data[ads_pkg::FRAME_W-ads_pkg::BYTE_W-1:0], i_rx_byte};
		end
	end

endmodule

// ==== hw/ads_sequencer.sv ====
`timescale 1ns/1ps
// ======================================
// ADS sequencer
// power-up, system command, register access
// and continuous read FSM, drives chip pins
// and the SPI master
// ======================================
module ads_sequencer #(
	parameter int T_POR     = 5000000,
	parameter int T_RESET   = 1760,
	parameter int T_CS_HOLD = 392
) (
	input  logic                       i_CLK,
	input  logic                       i_RSTN,
	// host side
	input  logic [2:0]                 i_ads_control,
	input  logic [ads_pkg::BYTE_W-1:0] i_ads_command,
	input  logic [ads_pkg::BYTE_W-1:0] i_ads_reg_addr,
	input  logic [ads_pkg::BYTE_W-1:0] i_ads_data_in,
	output logic                       o_ads_busy,
	output logic                       o_ads_init_done,
	output logic                       o_ads_data_ready,
	output logic [ads_pkg::BYTE_W-1:0] o_reg_data,
	output logic                       o_last_rreg,
	// chip pins
	output logic                       o_SPI_CSN,
	output logic                       o_ads_reset_n,
	output logic                       o_ads_start,
	// spi master
	output logic [ads_pkg::BYTE_W-1:0] o_tx_byte,
	output logic                       o_tx_valid,
	input  logic                       i_tx_ready,
	input  logic [ads_pkg::BYTE_W-1:0] i_rx_byte,
	input  logic                       i_rx_valid,
	// frame capture
	output logic                       o_frame_start,
	input  logic                       i_drdy_fall,
	input  logic                       i_frame_done
);

	localparam int WAIT_MAX = (T_POR > T_RESET) ?
		((T_POR > T_CS_HOLD) ? T_POR : T_CS_HOLD) :
		((T_RESET > T_CS_HOLD) ? T_RESET : T_CS_HOLD);
	localparam int WAIT_W = $clog2(WAIT_MAX + 1);

	typedef enum logic [2:0] {
		ST_POR,     // reset pin high, power-on wait
		ST_RESET,   // reset pin low
		ST_STANDBY,
		ST_XFER,    // strobe next byte
		ST_WAIT,    // byte on the wire
		ST_STREAM,  // between frames
		ST_HOLD     // CSN hold, then end of op
	} state_t;

	state_t                     r_state;
	logic [WAIT_W-1:0]          r_wait;   // shared by all timed states
	logic [2:0]                 r_op;     // current operation
	logic [ads_pkg::BYTE_W-1:0] r_cmd;    // first byte for commands
	logic [4:0]                 r_addr;
	logic [ads_pkg::BYTE_W-1:0] r_data;
	logic [3:0]                 r_idx;    // byte index in transfer
	logic [3:0]                 r_nbytes;
	logic                       r_stop;   // SDATAC seen while streaming
	ads_pkg::ads_opcode_u       w_first;
	logic                       w_is_reg;

	assign w_is_reg = (r_op == ads_pkg::CB_WREG) || (r_op == ads_pkg::CB_RREG);

	// first byte: command or opcode + address
	always_comb begin
		w_first.cmd = r_cmd;
		if (w_is_reg) begin
			w_first.fields.op   = (r_op == ads_pkg::CB_WREG) ? ads_pkg::OP_WREG : ads_pkg::OP_RREG;
			w_first.fields.addr = r_addr;
		end
	end

	// byte for the current index
	always_comb begin
		if (r_idx == 4'd0) begin
			o_tx_byte = w_first.cmd;
		end else if (r_idx == 4'd1 && w_is_reg) begin
			o_tx_byte = ads_pkg::OP_NUM_ONE;
		end else if (r_op == ads_pkg::CB_WREG) begin
			o_tx_byte = r_data;
		end else begin
			o_tx_byte = '0; // dummy for reads and frames
		end
	end

	// ======================================
	// main FSM
	// ======================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state          <= ST_POR;
			r_wait           <= '0;
			r_op             <= ads_pkg::CB_IDLE;
			r_cmd            <= '0;
			r_idx            <= '0;
			r_nbytes         <= '0;
			r_stop           <= 1'b0;
			o_ads_busy       <= 1'b0;
			o_ads_init_done  <= 1'b0;
			o_ads_data_ready <= 1'b0;
			o_last_rreg      <= 1'b0;
			o_SPI_CSN        <= 1'b1;
			o_ads_reset_n    <= 1'b1;
			o_ads_start      <= 1'b0;
			o_tx_valid       <= 1'b0;
			o_frame_start    <= 1'b0;
		end else begin
			o_tx_valid       <= 1'b0;
			o_frame_start    <= 1'b0;
			o_ads_data_ready <= i_frame_done;
			if (r_op == ads_pkg::CB_RDATAC && i_ads_control == ads_pkg::CB_SDATAC)
				r_stop <= 1'b1; // honoured between frames

			case (r_state)
				ST_POR: begin
					r_wait <= r_wait + 1'b1;
					if (r_wait == WAIT_W'(T_POR - 1)) begin
						r_wait        <= '0;
						o_ads_reset_n <= 1'b0;
						r_state       <= ST_RESET;
					end
				end

				ST_RESET: begin
					r_wait <= r_wait + 1'b1;
					if (r_wait == WAIT_W'(T_RESET - 1)) begin
						r_wait        <= '0;
						o_ads_reset_n <= 1'b1;
						r_op          <= ads_pkg::CB_SDATAC; // chip wakes in RDATAC
						r_cmd         <= ads_pkg::CM_SDATAC;
						r_idx         <= '0;
						r_nbytes      <= 4'd1;
						o_SPI_CSN     <= 1'b0;
						r_state       <= ST_XFER;
					end
				end

				ST_STANDBY: begin
					r_wait   <= '0;
					r_idx    <= '0;
					r_nbytes <= 4'd1;
					r_op     <= i_ads_control;
					case (i_ads_control)
						ads_pkg::CB_SYSCMD: begin
							o_ads_busy  <= 1'b1;
							o_last_rreg <= 1'b0;
							r_cmd       <= i_ads_command;
							case (i_ads_command)
								ads_pkg::CM_START: begin
									o_ads_start <= 1'b1; // pin only
									r_state     <= ST_HOLD;
								end
								ads_pkg::CM_STOP: begin
									o_ads_start <= 1'b0;
									r_state     <= ST_HOLD;
								end
								ads_pkg::CM_RESET: begin
									o_ads_reset_n <= 1'b0; // repeat reset pulse
									r_state       <= ST_RESET;
								end
								default: begin
									o_SPI_CSN <= 1'b0;
									r_state   <= ST_XFER;
								end
							endcase
						end
						ads_pkg::CB_WREG, ads_pkg::CB_RREG: begin
							o_ads_busy  <= 1'b1;
							o_last_rreg <= (i_ads_control == ads_pkg::CB_RREG);
							r_nbytes    <= 4'd3; // opcode, count, data or dummy
							o_SPI_CSN   <= 1'b0;
							r_state     <= ST_XFER;
						end
						ads_pkg::CB_RDATAC, ads_pkg::CB_SDATAC: begin
							o_ads_busy  <= 1'b1;
							o_last_rreg <= 1'b0;
							o_SPI_CSN   <= 1'b0;
							r_state     <= ST_XFER;
							if (i_ads_control == ads_pkg::CB_RDATAC) begin
								r_cmd       <= ads_pkg::CM_RDATAC;
								o_ads_start <= 1'b1; // conversions on
							end else begin
								r_cmd <= ads_pkg::CM_SDATAC;
							end
						end
						default: ; // idle or unused code
					endcase
				end

				ST_XFER: begin
					if (i_tx_ready) begin
						o_tx_valid <= 1'b1;
						r_state    <= ST_WAIT;
					end
				end

				ST_WAIT: begin
					if (i_rx_valid) begin
						r_idx <= r_idx + 1'b1;
						if (r_idx == r_nbytes - 1'b1)
							r_state <= (r_op == ads_pkg::CB_RDATAC) ? ST_STREAM : ST_HOLD;
						else
							r_state <= ST_XFER;
					end
				end

				ST_STREAM: begin
					r_idx <= '0;
					if (r_stop) begin
						r_stop      <= 1'b0;
						o_ads_start <= 1'b0;
						r_op        <= ads_pkg::CB_SDATAC;
						r_cmd       <= ads_pkg::CM_SDATAC;
						r_nbytes    <= 4'd1;
						r_state     <= ST_XFER;
					end else if (i_drdy_fall) begin
						o_frame_start <= 1'b1;
						r_cmd         <= '0; // dummy clocks for the frame
						r_nbytes      <= 4'(ads_pkg::FRAME_BYTES);
						r_state       <= ST_XFER;
					end
				end

				ST_HOLD: begin
					r_wait <= r_wait + 1'b1;
					if (r_wait == WAIT_W'(T_CS_HOLD - 1)) begin
						r_wait          <= '0;
						o_SPI_CSN       <= 1'b1;
						o_ads_busy      <= 1'b0;
						o_ads_init_done <= 1'b1; // first pass ends power-up
						r_state         <= ST_STANDBY;
					end
				end

				default: r_state <= ST_POR;
			endcase
		end
	end

	// operands and read-back byte
	always_ff @(posedge i_CLK) begin
		if (r_state == ST_STANDBY) begin
			r_addr <= i_ads_reg_addr[4:0];
			r_data <= i_ads_data_in;
		end
		if (r_state == ST_WAIT && i_rx_valid && r_op == ads_pkg::CB_RREG && r_idx == 4'd2)
			o_reg_data <= i_rx_byte;
	end

	// chip must be selected for any byte in flight
	a_csn_on_transfer: assert property (
		@(posedge i_CLK) disable iff (!i_RSTN)
		!i_tx_ready |-> !o_SPI_CSN
	);

endmodule

// ==== hw/ads1292_controller.sv ====
`timescale 1ns/1ps
// ======================================
// ADS1292 controller top level
// sequencer, SPI master and frame capture
// ======================================
module ads1292_controller #(
	parameter int CLKS_PER_HALF_BIT = 7,
	parameter int T_POR             = 5000000,
	parameter int T_RESET           = 1760,
	parameter int T_CS_HOLD         = 392
) (
	input  logic                        i_CLK,
	input  logic                        i_RSTN,
	// host side
	input  logic [2:0]                  i_ads_control,
	input  logic [ads_pkg::BYTE_W-1:0]  i_ads_command,
	input  logic [ads_pkg::BYTE_W-1:0]  i_ads_reg_addr,
	input  logic [ads_pkg::BYTE_W-1:0]  i_ads_data_in,
	output logic                        o_ads_busy,
	output logic                        o_ads_init_done,
	output logic                        o_ads_data_ready,
	output logic [ads_pkg::FRAME_W-1:0] o_ads_data_out,
	// chip side
	output logic                        o_SPI_CLK,
	output logic                        o_SPI_MOSI,
	input  logic                        i_SPI_MISO,
	output logic                        o_SPI_CSN,
	output logic                        o_ads_reset_n,
	output logic                        o_ads_start,
	input  logic                        i_ads_drdy_n
);

	logic [ads_pkg::BYTE_W-1:0]  w_tx_byte;
	logic                        w_tx_valid;
	logic                        w_tx_ready;
	logic [ads_pkg::BYTE_W-1:0]  w_rx_byte;
	logic                        w_rx_valid;
	logic                        w_frame_start;
	logic                        w_drdy_fall;
	logic                        w_frame_done;
	logic [ads_pkg::FRAME_W-1:0] w_frame_data;
	logic [ads_pkg::BYTE_W-1:0]  w_reg_data;
	logic                        w_last_rreg;

	// register byte takes the low byte after a register read
	assign o_ads_data_out = {w_frame_data[ads_pkg::FRAME_W-1:ads_pkg::BYTE_W],
		w_last_rreg ? w_reg_data : w_frame_data[ads_pkg::BYTE_W-1:0]};

	ads_sequencer #(
		.T_POR     (T_POR),
		.T_RESET   (T_RESET),
		.T_CS_HOLD (T_CS_HOLD)
	) seq_i (
		.i_CLK            (i_CLK),
		.i_RSTN           (i_RSTN),
		.i_ads_control    (i_ads_control),
		.i_ads_command    (i_ads_command),
		.i_ads_reg_addr   (i_ads_reg_addr),
		.i_ads_data_in    (i_ads_data_in),
		.o_ads_busy       (o_ads_busy),
		.o_ads_init_done  (o_ads_init_done),
		.o_ads_data_ready (o_ads_data_ready),
		.o_reg_data       (w_reg_data),
		.o_last_rreg      (w_last_rreg),
		.o_SPI_CSN        (o_SPI_CSN),
		.o_ads_reset_n    (o_ads_reset_n),
		.o_ads_start      (o_ads_start),
		.o_tx_byte        (w_tx_byte),
		.o_tx_valid       (w_tx_valid),
		.i_tx_ready       (w_tx_ready),
		.i_rx_byte        (w_rx_byte),
		.i_rx_valid       (w_rx_valid),
		.o_frame_start    (w_frame_start),
		.i_drdy_fall      (w_drdy_fall),
		.i_frame_done     (w_frame_done)
	);

	ads_spi_master #(
		.CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
	) spi_i (
		.i_CLK      (i_CLK),
		.i_RSTN     (i_RSTN),
		.i_tx_byte  (w_tx_byte),
		.i_tx_valid (w_tx_valid),
		.o_tx_ready (w_tx_ready),
		.o_rx_byte  (w_rx_byte),
		.o_rx_valid (w_rx_valid),
		.o_SPI_CLK  (o_SPI_CLK),
		.o_SPI_MOSI (o_SPI_MOSI),
		.i_SPI_MISO (i_SPI_MISO)
	);

	ads_frame_capture cap_i (
		.i_CLK         (i_CLK),
		.i_RSTN        (i_RSTN),
		.i_ads_drdy_n  (i_ads_drdy_n),
		.i_frame_start (w_frame_start),
		.i_rx_byte     (w_rx_byte),
		.i_rx_valid    (w_rx_valid),
		.o_drdy_fall   (w_drdy_fall),
		.o_frame_done  (w_frame_done),
		.o_frame_data  (w_frame_data)
	);

endmodule

// ==== testbench/ads_chip_model.sv ====
`timescale 1ns/1ps
// ======================================
// ADS1292 front-end model
// SPI mode 1 slave with 32 registers, DRDY
// generator and 9-byte stream frames
// ======================================
module ads_chip_model #(
	parameter int DRDY_PERIOD = 700,
	parameter int DRDY_LOW    = 8
) (
	input  logic                        i_CLK,
	input  logic                        i_RSTN,
	input  logic                        i_csn,
	input  logic                        i_sclk,
	input  logic                        i_mosi,
	output logic                        o_miso,
	input  logic                        i_reset_n,
	input  logic                        i_start,
	output logic                        o_drdy_n,
	input  logic [ads_pkg::FRAME_W-1:0] i_frame_word, // contents of frame o_frame_idx
	output logic [15:0]                 o_frame_idx,
	output logic [7:0]                  o_last_cmd,
	output logic [15:0]                 o_byte_cnt,
	output logic                        o_reset_seen
);

	logic [7:0]                  r_regs [32];
	logic                        r_sclk_q;  // previous SPI clock, edge detect
	logic [2:0]                  r_bit;
	logic [7:0]                  r_rx;
	logic [7:0]                  r_tx;
	logic [1:0]                  r_phase;   // 0 opcode, 1 count, 2 data
	logic                        r_read;
	logic [4:0]                  r_addr;
	logic                        r_rdatac;
	logic [3:0]                  r_fpos;    // next frame byte to load, 0 when none
	logic [ads_pkg::FRAME_W-1:0] r_frame;
	int                          r_timer;
	logic [7:0]                  w_byte;
	ads_pkg::ads_opcode_u        w_op;

	assign w_byte = {r_rx[6:0], i_mosi}; // whole byte on its last bit
	assign w_op   = w_byte;

	always @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			for (int i = 0; i < 32; i++)
				r_regs[i] <= '0;
			{r_sclk_q, r_bit, r_rx, r_tx, r_phase, r_read, r_addr} <= '0;
			{r_rdatac, r_fpos, r_frame, r_timer} <= '0;
			o_miso       <= 1'b0;
			o_drdy_n     <= 1'b1;
			o_frame_idx  <= '0;
			o_last_cmd   <= '0;
			o_byte_cnt   <= '0;
			o_reset_seen <= 1'b0;
		end else if (!i_reset_n) begin
			o_reset_seen <= 1'b1; // chip held in reset
			r_rdatac     <= 1'b0;
			r_phase      <= '0;
			r_fpos       <= '0;
			r_timer      <= 0;
			o_drdy_n     <= 1'b1;
		end else begin
			r_sclk_q <= i_sclk;
			if (i_csn) begin
				r_bit   <= '0;
				r_phase <= '0;
			end else if (i_sclk && !r_sclk_q) begin
				o_miso <= r_tx[7]; // leading edge, drive
				r_tx   <= {r_tx[6:0], 1'b0};
			end else if (!i_sclk && r_sclk_q) begin
				r_rx  <= w_byte; // trailing edge, sample
				r_bit <= r_bit + 1'b1;
				if (r_bit == 3'd7) begin
					o_byte_cnt <= o_byte_cnt + 1'b1;
					case (r_phase)
						2'd0: begin
							if (w_op.fields.op == ads_pkg::OP_WREG ||
								w_op.fields.op == ads_pkg::OP_RREG) begin
								r_addr  <= w_op.fields.addr;
								r_read  <= (w_op.fields.op == ads_pkg::OP_RREG);
								r_phase <= 2'd1;
							end else if (w_op.cmd != 8'h00) begin // 0x00 is a dummy
								o_last_cmd <= w_op.cmd;
								if (w_op.cmd == ads_pkg::CM_RDATAC)
									r_rdatac <= 1'b1;
								else if (w_op.cmd == ads_pkg::CM_SDATAC)
									r_rdatac <= 1'b0;
							end
						end
						2'd1: begin
							r_phase <= 2'd2;
							if (r_read)
								r_tx <= r_regs[r_addr]; // out on the next byte
						end
						default: begin
							r_phase <= 2'd0;
							if (!r_read)
								r_regs[r_addr] <= w_byte;
						end
					endcase
					if (r_fpos != 0) begin // rest of a frame
						if (r_fpos < 4'(ads_pkg::FRAME_BYTES))
							r_tx <= r_frame[ads_pkg::FRAME_W-1-ads_pkg::BYTE_W*r_fpos -: 8];
						r_fpos <= (r_fpos == 4'(ads_pkg::FRAME_BYTES)) ? 4'd0 : r_fpos + 1'b1;
					end
				end
			end

			// ======================================
			// data-ready generator
			// ======================================
			if (r_rdatac && i_start) begin
				r_timer <= r_timer + 1;
				if (r_timer == DRDY_PERIOD - 1) begin
					r_timer     <= 0;
					o_drdy_n    <= 1'b0;
					r_frame     <= i_frame_word;
					r_tx        <= i_frame_word[ads_pkg::FRAME_W-1 -: 8]; // status byte first
					r_fpos      <= 4'd1;
					o_frame_idx <= o_frame_idx + 1'b1;
				end else if (r_timer == DRDY_LOW - 1) begin
					o_drdy_n <= 1'b1;
				end
			end else begin
				r_timer  <= 0;
				o_drdy_n <= 1'b1;
			end
		end
	end

endmodule

// ==== testbench/tb_ads1292_controller.sv ====
`timescale 1ns/1ps
// ======================================
// ADS1292 controller testbench
// power-up, register access, system commands
// and continuous read against a chip model
// ======================================
module tb_ads1292_controller;

	localparam int CLKS_PER_HALF_BIT = 3;
	localparam int T_POR             = 40;
	localparam int T_RESET           = 20;
	localparam int T_CS_HOLD         = 6;
	localparam int DRDY_PERIOD       = 700;
	localparam int BYTE_CYC          = 16 * CLKS_PER_HALF_BIT + 4; // byte plus handshake
	// about 30 bytes, a dozen holds, 8 DRDY periods, doubled for margin
	localparam int MAX_CYCLES = 2 * (T_POR + T_RESET + 30 * BYTE_CYC + 12 * T_CS_HOLD +
		8 * DRDY_PERIOD);
	localparam logic [7:0] CMD_RDATA = 8'h12; // plain SPI command

	logic                        clk;
	logic                        rstn;
	logic [2:0]                  ctrl;
	logic [7:0]                  cmd;
	logic [7:0]                  addr;
	logic [7:0]                  din;
	logic                        busy;
	logic                        init_done;
	logic                        data_ready;
	logic [ads_pkg::FRAME_W-1:0] data_out;
	logic                        sclk;
	logic                        mosi;
	logic                        miso;
	logic                        csn;
	logic                        reset_n;
	logic                        start;
	logic                        drdy_n;
	logic [15:0]                 frame_idx;
	logic [ads_pkg::FRAME_W-1:0] model_word;
	logic [7:0]                  last_cmd;
	logic [15:0]                 byte_cnt;
	logic                        reset_seen;

	int          cycle_cnt = 0;
	int          n_checks = 0;
	int          n_errors = 0;
	int          test_checks0 = 0;
	int          test_errs0 = 0;
	int          frames_seen = 0;
	bit          stream_on = 1'b0; // frames expected
	logic [31:0] seed;
	logic [7:0]  shadow [32];       // expected register contents

	// ======================================
	// reference model
	// ======================================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [7:0] frame_byte(input int k, input int i);
		logic [31:0] s;
		s = lcg_next(32'd94 + 32'(k * ads_pkg::FRAME_BYTES + i));
		s = lcg_next(s);
		return s[23:16];
	endfunction

	// whole frame k, status byte in the top bits
	function automatic logic [ads_pkg::FRAME_W-1:0] frame_word(input int k);
		logic [ads_pkg::FRAME_W-1:0] w;
		w = '0;
		for (int i = 0; i < ads_pkg::FRAME_BYTES; i++)
			w = {w[ads_pkg::FRAME_W-ads_pkg::BYTE_W-1:0], frame_byte(k, i)};
		return w;
	endfunction

	assign model_word = frame_word(int'(frame_idx));

	ads1292_controller #(
		.CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT),
		.T_POR             (T_POR),
		.T_RESET           (T_RESET),
		.T_CS_HOLD         (T_CS_HOLD)
	) dut_i (
		.i_CLK            (clk),
		.i_RSTN           (rstn),
		.i_ads_control    (ctrl),
		.i_ads_command    (cmd),
		.i_ads_reg_addr   (addr),
		.i_ads_data_in    (din),
		.o_ads_busy       (busy),
		.o_ads_init_done  (init_done),
		.o_ads_data_ready (data_ready),
		.o_ads_data_out   (data_out),
		.o_SPI_CLK        (sclk),
		.o_SPI_MOSI       (mosi),
		.i_SPI_MISO       (miso),
		.o_SPI_CSN        (csn),
		.o_ads_reset_n    (reset_n),
		.o_ads_start      (start),
		.i_ads_drdy_n     (drdy_n)
	);

	ads_chip_model #(
		.DRDY_PERIOD (DRDY_PERIOD),
		.DRDY_LOW    (8)
	) model_i (
		.i_CLK        (clk),
		.i_RSTN       (rstn),
		.i_csn        (csn),
		.i_sclk       (sclk),
		.i_mosi       (mosi),
		.o_miso       (miso),
		.i_reset_n    (reset_n),
		.i_start      (start),
		.o_drdy_n     (drdy_n),
		.i_frame_word (model_word),
		.o_frame_idx  (frame_idx),
		.o_last_cmd   (last_cmd),
		.o_byte_cnt   (byte_cnt),
		.o_reset_seen (reset_seen)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [71:0] got,
		input logic [71:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d failed", name, n_checks - test_checks0,
			n_errors - test_errs0);
		test_checks0 = n_checks;
		test_errs0   = n_errors;
	endtask

	// present a control code in standby, drop it once busy is seen
	task automatic host_op(input logic [2:0] code, input logic [7:0] cmd_b,
		input logic [7:0] addr_b, input logic [7:0] data_b);
		while (busy || !init_done)
			@(posedge clk);
		ctrl <= code;
		cmd  <= cmd_b;
		addr <= addr_b;
		din  <= data_b;
		@(posedge clk);
		while (!busy)
			@(posedge clk);
		ctrl <= ads_pkg::CB_IDLE;
	endtask

	task automatic wait_idle();
		@(posedge clk);
		while (busy)
			@(posedge clk);
	endtask

	// stream compare, every data_ready pulse against the next frame
	always @(posedge clk) begin
		if (rstn && data_ready) begin
			frames_seen <= frames_seen + 1;
			if (stream_on) begin
				check_value($sformatf("frame %0d", frames_seen), data_out,
					frame_word(frames_seen));
				check_value("busy while streaming", busy, 1'b1);
			end else begin
				check_value("data_ready outside stream", 1'b1, 1'b0);
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: no finish after %0d cycles, at %0t ns", MAX_CYCLES, $time);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		int          frames_at_stop;
		logic [15:0] bytes0;
		bit          busy_in_powerup;
		logic [4:0]  wr_addr [3];
		ctrl            = ads_pkg::CB_IDLE;
		cmd             = '0;
		addr            = '0;
		din             = '0;
		rstn            = 1'b0;
		seed            = 32'd94;
		busy_in_powerup = 1'b0;
		repeat (5) @(posedge clk);
		check_value("busy in reset", busy, 1'b0); // reset values
		check_value("init_done in reset", init_done, 1'b0);
		check_value("data_ready in reset", data_ready, 1'b0);
		check_value("csn in reset", csn, 1'b1);
		check_value("reset pin in reset", reset_n, 1'b1);
		check_value("start in reset", start, 1'b0);
		check_value("spi clock in reset", sclk, 1'b0);
		rstn <= 1'b1;

		// ======================================
		// 1 power-up
		// ======================================
		while (!init_done) begin
			@(posedge clk);
			if (busy)
				busy_in_powerup = 1'b1;
		end
		check_value("busy during power-up", busy_in_powerup, 1'b0);
		check_value("reset pin pulsed", reset_seen, 1'b1);
		check_value("reset pin released", reset_n, 1'b1);
		check_value("power-up command", last_cmd, ads_pkg::CM_SDATAC);
		check_value("csn after power-up", csn, 1'b1);
		check_value("spi clock idle", sclk, 1'b0);
		end_test("test 1 power-up");

		// ======================================
		// 2 register write and read
		// ======================================
		for (int n = 0; n < 3; n++) begin
			seed       = lcg_next(seed);
			wr_addr[n] = seed[28:24];
			shadow[wr_addr[n]] = seed[23:16]; // later writes win
			host_op(ads_pkg::CB_WREG, 8'h00, {3'b000, wr_addr[n]}, seed[23:16]);
			wait_idle();
		end
		for (int n = 0; n < 3; n++) begin
			host_op(ads_pkg::CB_RREG, 8'h00, {3'b000, wr_addr[n]}, 8'h00);
			wait_idle();
			check_value($sformatf("read reg %0d", wr_addr[n]), data_out[7:0],
				shadow[wr_addr[n]]);
		end
		end_test("test 2 registers");

		// ======================================
		// 3 system commands
		// ======================================
		bytes0 = byte_cnt;
		host_op(ads_pkg::CB_SYSCMD, ads_pkg::CM_START, 8'h00, 8'h00);
		wait_idle();
		check_value("start pin high", start, 1'b1);
		check_value("no byte for start", byte_cnt, bytes0);
		host_op(ads_pkg::CB_SYSCMD, ads_pkg::CM_STOP, 8'h00, 8'h00);
		wait_idle();
		check_value("start pin low", start, 1'b0);
		check_value("no byte for stop", byte_cnt, bytes0);
		host_op(ads_pkg::CB_SYSCMD, CMD_RDATA, 8'h00, 8'h00);
		wait_idle();
		check_value("one byte for 0x12", byte_cnt, bytes0 + 16'd1);
		check_value("command logged", last_cmd, CMD_RDATA);
		end_test("test 3 system commands");

		// ======================================
		// 4 continuous read
		// ======================================
		stream_on = 1'b1;
		host_op(ads_pkg::CB_RDATAC, 8'h00, 8'h00, 8'h00);
		check_value("start pin in stream", start, 1'b1);
		while (frames_seen < 4)
			@(posedge clk);
		end_test("test 4 continuous read");

		// ======================================
		// 5 stop continuous read
		// ======================================
		ctrl <= ads_pkg::CB_SDATAC; // one cycle is latched
		@(posedge clk);
		ctrl <= ads_pkg::CB_IDLE;
		wait_idle();
		stream_on      = 1'b0;
		frames_at_stop = frames_seen;
		check_value("start pin after stop", start, 1'b0);
		check_value("stop command", last_cmd, ads_pkg::CM_SDATAC);
		check_value("csn after stop", csn, 1'b1);
		repeat (2 * DRDY_PERIOD) @(posedge clk);
		check_value("frames after stop", frames_seen, frames_at_stop);
		end_test("test 5 stop");

		$display("summary: %0d checks, %0d failed", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
hw/ads_pkg.sv
hw/ads_spi_master.sv
hw/ads_frame_capture.sv
hw/ads_sequencer.sv
hw/ads1292_controller.sv
testbench/ads_chip_model.sv
testbench/tb_ads1292_controller.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the ADS1292 controller testbench
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ads1292_controller -f compile.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	exit 1
fi
exit 0
